// File: hw/udp_video_pkg.sv
package udp_video_pkg;

	// expected header values of an accepted stream packet
	localparam logic [31:0] ipv4_dst_rec = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [15:0] dst_port_rec = 16'd12345;
	localparam logic [15:0] ethernet_type = 16'h0800;
	localparam logic [7:0] ip_version = 8'h45;
	// udp
	localparam logic [7:0] ip_protocol = 8'h11;

	// byte offsets, counted from the first byte after the 0xd5 delimiter
	localparam logic [10:0] off_eth_type = 11'h00c;
	localparam logic [10:0] off_ip_ver = 11'h00e;
	localparam logic [10:0] off_proto = 11'h017;
	localparam logic [10:0] off_ip_dst = 11'h01e;
	localparam logic [10:0] off_dst_port = 11'h024;
	localparam logic [10:0] off_hdr0 = 11'h02a;
	localparam logic [10:0] off_hdr1 = 11'h02b;
	// last byte that still yields pixel data
	localparam logic [10:0] off_end = 11'd1323;

	// pixel word fifo
	localparam int fifo_depth = 16;
	localparam int fifo_aw = 4;

	// req/ack sender states
	localparam logic [1:0] tx_idle = 2'd0;
	localparam logic [1:0] tx_req = 2'd1;
	localparam logic [1:0] tx_ack_low = 2'd2;

	// one pixel pair tagged with its line
	typedef struct packed {
		logic [10:0] y;
		logic        x_lsb;
		logic [7:0]  pix0;
		logic [7:0]  pix1;
	} pix_word_t;

	// first two payload bytes, as received or as line fields
	typedef union packed {
		struct packed {
			logic [7:0] hdr0;
			logic [7:0] hdr1;
		} raw;
		struct packed {
			logic [7:0] y_lo;
			logic [3:0] x_lo;
			logic [3:0] y_hi;
		} line;
	} line_hdr_u;

endpackage

// File: hw/gmii_udp_parser.sv
module gmii_udp_parser (
	input  logic                     clk125,
	input  logic                     sys_rst,
	input  logic                     id,
	input  logic [7:0]               rxd,
	input  logic                     rx_dv,
	output udp_video_pkg::pix_word_t word,
	output logic                     word_valid,
	output logic                     packet_en
);

	// frame and header state
	logic                     in_frame;
	logic [10:0]              rx_count;
	logic                     hdr_done;
	logic                     odd_byte;

	// captured header fields
	logic [15:0]              eth_type;
	logic [7:0]               ip_ver;
	logic [7:0]               ip_proto;
	logic [31:0]              ip_dst;
	logic [15:0]              dst_port;
	udp_video_pkg::line_hdr_u line_hdr;

	logic [7:0]               dst_last;
	logic                     hdr_match;
	logic                     pix_take;

	// board id shifts the last address byte
	assign dst_last = udp_video_pkg::ipv4_dst_rec[7:0] + {7'd0, id};

	assign hdr_match = (eth_type == udp_video_pkg::ethernet_type) &&
		(ip_ver == udp_video_pkg::ip_version) &&
		(ip_proto == udp_video_pkg::ip_protocol) &&
		(ip_dst[31:8] == udp_video_pkg::ipv4_dst_rec[31:8]) &&
		(ip_dst[7:0] == dst_last) &&
		(dst_port == udp_video_pkg::dst_port_rec);

	// pixel bytes start right after the two line header bytes
	assign pix_take = rx_dv && packet_en && hdr_done;

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			in_frame <= 1'b0;
			rx_count <= 11'd0;
			packet_en <= 1'b0;
			hdr_done <= 1'b0;
		end else if (!rx_dv) begin
			// end of frame, wait for the next delimiter
			in_frame <= 1'b0;
			rx_count <= 11'd0;
			packet_en <= 1'b0;
			hdr_done <= 1'b0;
		end else begin
			if (!in_frame && rxd == 8'hd5) begin
				in_frame <= 1'b1;
			end
			if (in_frame) begin
				// hold at the top so a long frame never matches twice
				if (rx_count != 11'h7ff) begin
					rx_count <= rx_count + 11'd1;
				end
				if (rx_count == udp_video_pkg::off_hdr0 && hdr_match) begin
					packet_en <= 1'b1;
				end
				if (rx_count == udp_video_pkg::off_hdr1 && packet_en) begin
					hdr_done <= 1'b1;
				end
				if (rx_count == udp_video_pkg::off_end) begin
					packet_en <= 1'b0;
					hdr_done <= 1'b0;
				end
			end
		end
	end

	// header field capture by byte offset
	always_ff @(posedge clk125) begin
		if (rx_dv && in_frame) begin
			case (rx_count)
				udp_video_pkg::off_eth_type: begin
					eth_type[15:8] <= rxd;
				end
				udp_video_pkg::off_eth_type + 11'd1: begin
					eth_type[7:0] <= rxd;
				end
				udp_video_pkg::off_ip_ver: begin
					ip_ver <= rxd;
				end
				udp_video_pkg::off_proto: begin
					ip_proto <= rxd;
				end
				udp_video_pkg::off_ip_dst: begin
					ip_dst[31:24] <= rxd;
				end
				udp_video_pkg::off_ip_dst + 11'd1: begin
					ip_dst[23:16] <= rxd;
				end
				udp_video_pkg::off_ip_dst + 11'd2: begin
					ip_dst[15:8] <= rxd;
				end
				udp_video_pkg::off_ip_dst + 11'd3: begin
					ip_dst[7:0] <= rxd;
				end
				udp_video_pkg::off_dst_port: begin
					dst_port[15:8] <= rxd;
				end
				udp_video_pkg::off_dst_port + 11'd1: begin
					dst_port[7:0] <= rxd;
				end
				udp_video_pkg::off_hdr0: begin
					if (hdr_match) begin
						line_hdr.raw.hdr0 <= rxd;
					end
				end
				udp_video_pkg::off_hdr1: begin
					if (packet_en) begin
						line_hdr.raw.hdr1 <= rxd;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// pair phase and write strobe
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			odd_byte <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			if (pix_take) begin
				odd_byte <= !odd_byte;
				word_valid <= odd_byte;
			end else begin
				odd_byte <= 1'b0;
			end
		end
	end

	// even byte opens a word with its line tag, odd byte completes it
	always_ff @(posedge clk125) begin
		if (pix_take) begin
			if (!odd_byte) begin
				word.y <= {line_hdr.line.y_hi[2:0], line_hdr.line.y_lo};
				word.x_lsb <= line_hdr.line.x_lo[0];
				word.pix0 <= rxd;
			end else begin
				word.pix1 <= rxd;
			end
		end
	end

endmodule

// File: hw/pixel_fifo.sv
module pixel_fifo (
	input  logic                     clk125,
	input  logic                     sys_rst,
	input  udp_video_pkg::pix_word_t wr_word,
	input  logic                     wr_en,
	output udp_video_pkg::pix_word_t rd_word,
	output logic                     rd_empty,
	input  logic                     rd_pop,
	output logic                     overflow
);

	udp_video_pkg::pix_word_t          mem [0:udp_video_pkg::fifo_depth-1];
	logic [udp_video_pkg::fifo_aw-1:0] wr_ptr;
	logic [udp_video_pkg::fifo_aw-1:0] rd_ptr;
	// one extra bit to tell full from empty
	logic [udp_video_pkg::fifo_aw:0]   count;
	logic                              full;
	logic                              do_write;
	logic                              do_read;

	assign full = (count == (udp_video_pkg::fifo_aw + 1)'(udp_video_pkg::fifo_depth));
	assign rd_empty = (count == '0);
	assign do_write = wr_en && !full;
	assign do_read = rd_pop && !rd_empty;

	// head word straight from the array
	assign rd_word = mem[rd_ptr];

	always_ff @(posedge clk125) begin
		if (do_write) begin
			mem[wr_ptr] <= wr_word;
		end
	end

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// a refused write is reported one cycle later
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			overflow <= 1'b0;
		end else begin
			overflow <= wr_en && full;
		end
	end

endmodule

// File: hw/pixel_req_ack_tx.sv
module pixel_req_ack_tx (
	input  logic                     clk125,
	input  logic                     sys_rst,
	input  udp_video_pkg::pix_word_t rd_word,
	input  logic                     rd_empty,
	output logic                     rd_pop,
	output udp_video_pkg::pix_word_t out_word,
	output logic                     out_req,
	input  logic                     out_ack
);

	logic [1:0] state;

	// take the head word whenever idle and something is queued
	assign rd_pop = (state == udp_video_pkg::tx_idle) && !rd_empty;

	// word is loaded while out_req is still low
	always_ff @(posedge clk125) begin
		if (rd_pop) begin
			out_word <= rd_word;
		end
	end

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			state <= udp_video_pkg::tx_idle;
			out_req <= 1'b0;
		end else begin
			case (state)
				udp_video_pkg::tx_idle: begin
					if (!rd_empty) begin
						state <= udp_video_pkg::tx_req;
						out_req <= 1'b1;
					end
				end
				udp_video_pkg::tx_req: begin
					// consumer has taken the word
					if (out_ack) begin
						state <= udp_video_pkg::tx_ack_low;
						out_req <= 1'b0;
					end
				end
				udp_video_pkg::tx_ack_low: begin
					// handshake closes once ack is back low
					if (!out_ack) begin
						state <= udp_video_pkg::tx_idle;
					end
				end
				default: begin
					state <= udp_video_pkg::tx_idle;
					out_req <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: hw/udp_video_rx_top.sv
module udp_video_rx_top (
	input  logic                     clk125,
	input  logic                     sys_rst,
	input  logic                     id,
	input  logic [7:0]               rxd,
	input  logic                     rx_dv,
	output udp_video_pkg::pix_word_t out_word,
	output logic                     out_req,
	input  logic                     out_ack,
	output logic                     packet_en,
	output logic                     overflow
);

	// parser to fifo
	udp_video_pkg::pix_word_t word;
	logic                     word_valid;

	// fifo to sender
	udp_video_pkg::pix_word_t rd_word;
	logic                     rd_empty;
	logic                     rd_pop;

	gmii_udp_parser u_parser (
		.clk125     (clk125),
		.sys_rst    (sys_rst),
		.id         (id),
		.rxd        (rxd),
		.rx_dv      (rx_dv),
		.word       (word),
		.word_valid (word_valid),
		.packet_en  (packet_en)
	);

	pixel_fifo u_fifo (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.wr_word  (word),
		.wr_en    (word_valid),
		.rd_word  (rd_word),
		.rd_empty (rd_empty),
		.rd_pop   (rd_pop),
		.overflow (overflow)
	);

	pixel_req_ack_tx u_tx (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.rd_word  (rd_word),
		.rd_empty (rd_empty),
		.rd_pop   (rd_pop),
		.out_word (out_word),
		.out_req  (out_req),
		.out_ack  (out_ack)
	);

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen (
	output logic clk125,
	output logic sys_rst
);

	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	initial begin
		clk125 = 1'b0;
		forever begin
			#20 clk125 = ~clk125;
		end
	end

	// reset held over the first four rising edges, released on a falling edge
	initial begin
		sys_rst = 1'b1;
		repeat (4) @(posedge clk125);
		@(negedge clk125);
		sys_rst = 1'b0;
	end

endmodule

// File: dv/udp_video_rx_tb.sv
module udp_video_rx_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int idle_limit = 4000;
	localparam int ack_limit = 20;
	localparam int drain_limit = 4000;

	logic                     clk125;
	logic                     sys_rst;
	logic                     id;
	logic [7:0]               rxd;
	logic                     rx_dv;
	udp_video_pkg::pix_word_t out_word;
	logic                     out_req;
	logic                     out_ack;
	logic                     packet_en;
	logic                     overflow;

	// expected words in arrival order
	udp_video_pkg::pix_word_t exp_q[$];
	int                       errors = 0;
	int                       seed = 6;
	int                       ack_delay = 0;
	logic                     ack_random = 1'b0;
	int                       ovf_count = 0;

	tb_clock_gen u_clock (
		.clk125  (clk125),
		.sys_rst (sys_rst)
	);

	udp_video_rx_top UUT (
		.clk125    (clk125),
		.sys_rst   (sys_rst),
		.id        (id),
		.rxd       (rxd),
		.rx_dv     (rx_dv),
		.out_word  (out_word),
		.out_req   (out_req),
		.out_ack   (out_ack),
		.packet_en (packet_en),
		.overflow  (overflow)
	);

	task automatic check_word(input string name, input udp_video_pkg::pix_word_t exp,
		input udp_video_pkg::pix_word_t act);
		if (act !== exp) begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR at %0t: %s expected %b got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERROR at %0t: %s expected %0d got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic drive_byte(input logic [7:0] value);
		rxd = value;
		rx_dv = 1'b1;
		@(negedge clk125);
	endtask

	// preamble, delimiter, then eth/ip/udp header with only the checked fields set
	task automatic send_frame(input logic [15:0] etype, input logic [7:0] ver,
		input logic [7:0] proto, input logic [31:0] dst, input logic [15:0] port,
		input logic [7:0] hdr0, input logic [7:0] hdr1);
		logic [7:0] hdr [0:43];
		for (int i = 0; i < 44; i++) begin
			hdr[i] = 8'h00;
		end
		{hdr[12], hdr[13]} = etype;
		hdr[14] = ver;
		hdr[23] = proto;
		{hdr[30], hdr[31], hdr[32], hdr[33]} = dst;
		{hdr[36], hdr[37]} = port;
		// line header in the first two payload bytes
		hdr[42] = hdr0;
		hdr[43] = hdr1;
		repeat (7) drive_byte(8'h55);
		drive_byte(8'hd5);
		for (int i = 0; i < 44; i++) begin
			drive_byte(hdr[i]);
		end
	endtask

	// consecutive pixel pairs of one line
	task automatic queue_words(input logic [10:0] y, input logic x, input logic [7:0] pix,
		input int cnt);
		udp_video_pkg::pix_word_t w;
		for (int k = 0; k < cnt; k++) begin
			w.y = y;
			w.x_lsb = x;
			w.pix0 = pix + 8'(2 * k);
			w.pix1 = w.pix0 + 8'd1;
			exp_q.push_back(w);
		end
	endtask

	always @(negedge clk125) begin
		if (overflow === 1'b1) begin
			ovf_count++;
		end
	end

	// consumer side of the four-phase handshake
	initial begin : consumer
		int   t;
		int   d;
		logic running;
		out_ack = 1'b0;
		running = 1'b1;
		while (running) begin
			t = 0;
			while (out_req !== 1'b1 && t < idle_limit) begin
				@(negedge clk125);
				t++;
			end
			if (out_req !== 1'b1) begin
				$display("consumer stopped: no request from the DUT for %0d cycles", idle_limit);
				errors++;
				running = 1'b0;
			end else begin
				if (exp_q.size() == 0) begin
					$display("unexpected word %h at %0t with nothing expected", out_word, $time);
					errors++;
				end else begin
					check_word("out_word", exp_q.pop_front(), out_word);
				end
				d = ack_random ? ($random(seed) & 7) : ack_delay;
				repeat (d) @(negedge clk125);
				out_ack = 1'b1;
				t = 0;
				while (out_req === 1'b1 && t < ack_limit) begin
					@(negedge clk125);
					t++;
				end
				if (out_req === 1'b1) begin
					$display("consumer stopped: out_req still high %0d cycles after ack",
						ack_limit);
					errors++;
					running = 1'b0;
				end
				out_ack = 1'b0;
				@(negedge clk125);
			end
		end
	end

	initial begin : stimulus
		int          fd;
		int          t;
		int          n;
		int          val;
		int          cnt;
		int          first_err;
		int          ovf_base;
		int          tests;
		string       line;
		string       cmd;
		string       name;
		logic [15:0] etype;
		logic [15:0] port;
		logic [7:0]  ver;
		logic [7:0]  proto;
		logic [7:0]  b0;
		logic [7:0]  b1;
		logic [31:0] dst;
		logic [10:0] y;
		id = 1'b0;
		rxd = 8'h00;
		rx_dv = 1'b0;
		ovf_base = 0;
		tests = 1;
		first_err = 0;
		name = "";
		t = 0;
		while (sys_rst !== 1'b0 && t < 50) begin
			@(negedge clk125);
			t++;
		end
		if (sys_rst !== 1'b0) begin
			$display("reset was still asserted after %0d cycles", t);
			errors++;
		end
		@(negedge clk125);
		check_bit("out_req", 1'b0, out_req);
		check_bit("packet_en", 1'b0, packet_en);
		check_bit("overflow", 1'b0, overflow);
		$display("test reset done, %0d errors", errors);
		fd = $fopen("dv/udp_video_stimulus.txt", "r");
		if (fd == 0) begin
			$display("the stimulus file dv/udp_video_stimulus.txt could not be opened");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				cmd = "";
				n = $sscanf(line, "%s", cmd);
				case (cmd)
					"test": begin
						n = $sscanf(line, "%s %s", cmd, name);
						first_err = errors;
					end
					"id": begin
						n = $sscanf(line, "%s %d", cmd, val);
						id = val[0];
					end
					"ack": begin
						n = $sscanf(line, "%s %d", cmd, ack_delay);
						ack_random = 1'b0;
					end
					"ackrand": begin
						ack_random = 1'b1;
					end
					"frame": begin
						n = $sscanf(line, "%s %h %h %h %h %h %h %h", cmd, etype, ver, proto,
							dst, port, b0, b1);
						send_frame(etype, ver, proto, dst, port, b0, b1);
					end
					"byte": begin
						n = $sscanf(line, "%s %h %d %h", cmd, b0, val, b1);
						for (int k = 0; k < val; k++) begin
							drive_byte(b0 + b1 * 8'(k));
						end
					end
					"gap": begin
						n = $sscanf(line, "%s %d", cmd, val);
						rx_dv = 1'b0;
						rxd = 8'h00;
						repeat (val) @(negedge clk125);
					end
					"pen": begin
						n = $sscanf(line, "%s %d", cmd, val);
						check_bit("packet_en", val[0], packet_en);
					end
					"ovf": begin
						n = $sscanf(line, "%s %d", cmd, val);
						check_count("overflow pulses", val, ovf_count - ovf_base);
						ovf_base = ovf_count;
					end
					"expect": begin
						n = $sscanf(line, "%s %h %d %h %d", cmd, y, val, b0, cnt);
						queue_words(y, val[0], b0, cnt);
					end
					"check": begin
						t = 0;
						while (exp_q.size() != 0 && t < drain_limit) begin
							@(negedge clk125);
							t++;
						end
						if (exp_q.size() != 0) begin
							$display("%0d expected words of test %s never arrived",
								exp_q.size(), name);
							errors++;
							exp_q.delete();
						end
						$display("test %s done, %0d errors", name, errors - first_err);
						tests++;
					end
					default: begin
						if (cmd != "" && cmd.substr(0, 0) != "#") begin
							$display("unknown stimulus line: %s", line);
							errors++;
						end
					end
				endcase
			end
			$fclose(fd);
		end
		repeat (20) @(negedge clk125);
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: dv/udp_video_stimulus.txt
# frame: eth_type ip_ver proto dst_ip dst_port hdr0 hdr1 (hex)   byte: first count step
# expect: y x_lsb pix0 count, pix1 = pix0 + 1   gap/ack: cycles   id/pen/ovf: value
test match
ack 2
expect 305 1 10 4
frame 0800 45 11 c0a80001 3039 05 13
pen 1
byte 10 8 01
gap 6
pen 0
check
test reject
frame 0800 45 11 c0a80001 3031 00 01
pen 0
byte 02 4 01
gap 4
frame 0800 45 06 c0a80001 3039 00 01
byte 02 4 01
gap 4
frame 86dd 45 11 c0a80001 3039 00 01
byte 02 4 01
gap 4
frame 0800 45 11 c0a80002 3039 00 01
byte 02 4 01
gap 4
check
test board_id
id 1
expect 42a 0 80 2
frame 0800 45 11 c0a80001 3039 40 41
byte 42 4 01
gap 4
frame 0800 45 11 c0a80002 3039 2a 04
byte 80 4 01
gap 4
check
test truncate
id 0
expect 107 0 30 2
frame 0800 45 11 c0a80001 3039 07 21
byte 30 5 01
gap 4
check
test ack_random
ackrand
expect 209 1 50 12
frame 0800 45 11 c0a80001 3039 09 12
byte 50 24 01
gap 4
ovf 0
check
test overflow
ack 150
expect 001 0 a0 1
expect 002 1 00 16
frame 0800 45 11 c0a80001 3039 01 00
byte a0 2 01
gap 4
frame 0800 45 11 c0a80001 3039 02 10
byte 00 40 01
gap 4
ack 0
ovf 4
check

// File: udp_video_rx.f
hw/udp_video_pkg.sv
hw/gmii_udp_parser.sv
hw/pixel_fifo.sv
hw/pixel_req_ack_tx.sv
hw/udp_video_rx_top.sv
dv/tb_clock_gen.sv
dv/udp_video_rx_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= udp_video_rx_tb
RTL_TOP   ?= udp_video_rx_top
FILELIST  ?= udp_video_rx.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter hw/%,$(SRCS))
SIM      := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q -x "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
